/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_aes256_dec \
		-f src.f --Mdir obj_dir
	@out="$$(./obj_dir/Vtb_aes256_dec)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

/* aes256_dec.sv */
`timescale 1ns/10ps
`default_nettype none

module aes256_dec #(
    parameter int ROUNDS = 14
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   start,
    input  aes_dec_pkg::block_t    cipher_text,
    input  aes_dec_pkg::block_t    round_key,
    output aes_dec_pkg::key_addr_t key_addr,
    output logic                   done,
    output aes_dec_pkg::block_t    plain_text
);
    import aes_dec_pkg::*;

    logic       load_shift;
    logic       add_key_first;
    logic       add_key;
    logic       inv_mix;
    logic       collect_full;
    byte_beat_t shift_beat;
    byte_beat_t sbox_beat;
    state_t     collected;
    state_t     work_state;

    // Sequencing and key index
    aes_dec_ctrl #(
        .ROUNDS(ROUNDS)
    ) u_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .start        (start),
        .collect_full (collect_full),
        .load_shift   (load_shift),
        .add_key_first(add_key_first),
        .add_key      (add_key),
        .inv_mix      (inv_mix),
        .done         (done),
        .key_addr     (key_addr)
    );

    // Inverse ShiftRows then one byte per cycle
    inv_shift_serializer u_serializer (
        .clk       (clk),
        .resetn    (resetn),
        .load_shift(load_shift),
        .state_in  (work_state),
        .beat_out  (shift_beat)
    );

    inv_sbox_rom u_sbox (
        .clk     (clk),
        .resetn  (resetn),
        .beat_in (shift_beat),
        .beat_out(sbox_beat)
    );

    // Rebuilds the state and flags the controller
    byte_collector u_collector (
        .clk      (clk),
        .resetn   (resetn),
        .beat_in  (sbox_beat),
        .state_out(collected),
        .full     (collect_full)
    );

    round_key_mixer u_mixer (
        .clk          (clk),
        .resetn       (resetn),
        .add_key_first(add_key_first),
        .add_key      (add_key),
        .inv_mix      (inv_mix),
        .cipher_text  (cipher_text),
        .round_key    (round_key),
        .collected    (collected),
        .state_out    (work_state)
    );

    // Result held until the next block completes
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            plain_text <= '0;
        else if (done)
            plain_text <= block_t'(work_state);
    end

endmodule

`default_nettype wire

/* aes_dec_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module aes_dec_ctrl #(
    parameter int ROUNDS = 14
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   start,
    input  logic                   collect_full,
    output logic                   load_shift,
    output logic                   add_key_first,
    output logic                   add_key,
    output logic                   inv_mix,
    output logic                   done,
    output aes_dec_pkg::key_addr_t key_addr
);
    import aes_dec_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_first_key,
        st_shift,
        st_wait_bytes,
        st_add_key,
        st_mix,
        st_finish
    } ctrl_state_t;

    // Index of the first key used, and also the number of the last round
    localparam key_addr_t LAST_ROUND = key_addr_t'(ROUNDS);

    ctrl_state_t state;
    ctrl_state_t state_next;
    key_addr_t   round_cnt;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            state <= st_idle;
        else
            state <= state_next;
    end

    // Round number, 0 during the initial key add
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            round_cnt <= '0;
        else if (state == st_finish)
            round_cnt <= '0;
        else if (state == st_first_key || state == st_mix)
            round_cnt <= round_cnt + 1'b1;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            // Start only counts here, a start during a run is dropped
            st_idle:
                if (start)
                    state_next = st_first_key;
            st_first_key:
                state_next = st_shift;
            st_shift:
                state_next = st_wait_bytes;
            // Collector tells us when all sixteen bytes are back
            st_wait_bytes:
                if (collect_full)
                    state_next = st_add_key;
            // Last round skips inverse MixColumns
            st_add_key:
                if (round_cnt == LAST_ROUND)
                    state_next = st_finish;
                else
                    state_next = st_mix;
            st_mix:
                state_next = st_shift;
            st_finish:
                state_next = st_idle;
            default:
                state_next = st_idle;
        endcase
    end

    // Strobes straight from the state
    assign add_key_first = (state == st_first_key);
    assign load_shift    = (state == st_shift);
    assign add_key       = (state == st_add_key);
    assign inv_mix       = (state == st_mix);
    assign done          = (state == st_finish);

    // Keys are consumed from the last one down to key 0
    assign key_addr = LAST_ROUND - round_cnt;

    a_done_single: assert property (@(posedge clk) disable iff (!resetn)
        done |=> !done)
        else $error("done held for more than one cycle");

    a_key_addr_range: assert property (@(posedge clk) disable iff (!resetn)
        key_addr <= LAST_ROUND)
        else $error("key_addr beyond the configured round count");

    a_rounds_param: assert property (@(posedge clk)
        (ROUNDS <= MAX_ROUNDS) && (ROUNDS inside {10, 12, 14}))
        else $error("ROUNDS must be 10, 12 or 14");

endmodule

`default_nettype wire

/* aes_dec_pkg.sv */
`default_nettype none

package aes_dec_pkg;

    // Flat 128-bit block for ciphertext, plaintext and round keys
    typedef logic [127:0] block_t;

    // Byte b is row b%4 of column b/4, found at bits 8b+7:8b
    typedef logic [15:0][7:0] state_t;

    // One byte on the serial path
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } byte_beat_t;

    // Round key index, 0 to 14
    typedef logic [3:0] key_addr_t;

    // Upper bound on the round count (AES-256)
    localparam int MAX_ROUNDS = 14;

    // Inverse S-box, indexed by the substituted byte
    localparam logic [7:0] INV_SBOX [0:255] = '{
        8'h52, 8'h09, 8'h6a, 8'hd5, 8'h30, 8'h36, 8'ha5, 8'h38,
        8'hbf, 8'h40, 8'ha3, 8'h9e, 8'h81, 8'hf3, 8'hd7, 8'hfb,
        8'h7c, 8'he3, 8'h39, 8'h82, 8'h9b, 8'h2f, 8'hff, 8'h87,
        8'h34, 8'h8e, 8'h43, 8'h44, 8'hc4, 8'hde, 8'he9, 8'hcb,
        8'h54, 8'h7b, 8'h94, 8'h32, 8'ha6, 8'hc2, 8'h23, 8'h3d,
        8'hee, 8'h4c, 8'h95, 8'h0b, 8'h42, 8'hfa, 8'hc3, 8'h4e,
        8'h08, 8'h2e, 8'ha1, 8'h66, 8'h28, 8'hd9, 8'h24, 8'hb2,
        8'h76, 8'h5b, 8'ha2, 8'h49, 8'h6d, 8'h8b, 8'hd1, 8'h25,
        8'h72, 8'hf8, 8'hf6, 8'h64, 8'h86, 8'h68, 8'h98, 8'h16,
        8'hd4, 8'ha4, 8'h5c, 8'hcc, 8'h5d, 8'h65, 8'hb6, 8'h92,
        8'h6c, 8'h70, 8'h48, 8'h50, 8'hfd, 8'hed, 8'hb9, 8'hda,
        8'h5e, 8'h15, 8'h46, 8'h57, 8'ha7, 8'h8d, 8'h9d, 8'h84,
        8'h90, 8'hd8, 8'hab, 8'h00, 8'h8c, 8'hbc, 8'hd3, 8'h0a,
        8'hf7, 8'he4, 8'h58, 8'h05, 8'hb8, 8'hb3, 8'h45, 8'h06,
        8'hd0, 8'h2c, 8'h1e, 8'h8f, 8'hca, 8'h3f, 8'h0f, 8'h02,
        8'hc1, 8'haf, 8'hbd, 8'h03, 8'h01, 8'h13, 8'h8a, 8'h6b,
        8'h3a, 8'h91, 8'h11, 8'h41, 8'h4f, 8'h67, 8'hdc, 8'hea,
        8'h97, 8'hf2, 8'hcf, 8'hce, 8'hf0, 8'hb4, 8'he6, 8'h73,
        8'h96, 8'hac, 8'h74, 8'h22, 8'he7, 8'had, 8'h35, 8'h85,
        8'he2, 8'hf9, 8'h37, 8'he8, 8'h1c, 8'h75, 8'hdf, 8'h6e,
        8'h47, 8'hf1, 8'h1a, 8'h71, 8'h1d, 8'h29, 8'hc5, 8'h89,
        8'h6f, 8'hb7, 8'h62, 8'h0e, 8'haa, 8'h18, 8'hbe, 8'h1b,
        8'hfc, 8'h56, 8'h3e, 8'h4b, 8'hc6, 8'hd2, 8'h79, 8'h20,
        8'h9a, 8'hdb, 8'hc0, 8'hfe, 8'h78, 8'hcd, 8'h5a, 8'hf4,
        8'h1f, 8'hdd, 8'ha8, 8'h33, 8'h88, 8'h07, 8'hc7, 8'h31,
        8'hb1, 8'h12, 8'h10, 8'h59, 8'h27, 8'h80, 8'hec, 8'h5f,
        8'h60, 8'h51, 8'h7f, 8'ha9, 8'h19, 8'hb5, 8'h4a, 8'h0d,
        8'h2d, 8'he5, 8'h7a, 8'h9f, 8'h93, 8'hc9, 8'h9c, 8'hef,
        8'ha0, 8'he0, 8'h3b, 8'h4d, 8'hae, 8'h2a, 8'hf5, 8'hb0,
        8'hc8, 8'heb, 8'hbb, 8'h3c, 8'h83, 8'h53, 8'h99, 8'h61,
        8'h17, 8'h2b, 8'h04, 8'h7e, 8'hba, 8'h77, 8'hd6, 8'h26,
        8'he1, 8'h69, 8'h14, 8'h63, 8'h55, 8'h21, 8'h0c, 8'h7d
    };

endpackage

`default_nettype wire

/* byte_collector.sv */
`timescale 1ns/10ps
`default_nettype none

module byte_collector (
    input  logic                    clk,
    input  logic                    resetn,
    input  aes_dec_pkg::byte_beat_t beat_in,
    output aes_dec_pkg::state_t     state_out,
    output logic                    full
);
    import aes_dec_pkg::*;

    state_t     collect_q;
    logic [3:0] byte_cnt;

    // New byte enters at the top, first byte ends up in slot 0
    always_ff @(posedge clk)
    begin
        if (beat_in.valid)
            collect_q <= {beat_in.data, collect_q[15:1]};
    end

    // Counter wraps to zero on the sixteenth byte
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            byte_cnt <= '0;
            full     <= 1'b0;
        end
        else
        begin
            full <= beat_in.valid && (byte_cnt == 4'd15);
            if (beat_in.valid)
                byte_cnt <= byte_cnt + 1'b1;
        end
    end

    assign state_out = collect_q;

endmodule

`default_nettype wire

/* inv_sbox_rom.sv */
`timescale 1ns/10ps
`default_nettype none

module inv_sbox_rom (
    input  logic                    clk,
    input  logic                    resetn,
    input  aes_dec_pkg::byte_beat_t beat_in,
    output aes_dec_pkg::byte_beat_t beat_out
);
    import aes_dec_pkg::*;

    logic       valid_q;
    logic [7:0] data_q;

    // Valid follows the lookup by one cycle
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            valid_q <= 1'b0;
        else
            valid_q <= beat_in.valid;
    end

    // Registered table read, only on real bytes
    always_ff @(posedge clk)
    begin
        if (beat_in.valid)
            data_q <= INV_SBOX[beat_in.data];
    end

    assign beat_out.valid = valid_q;
    assign beat_out.data  = data_q;

endmodule

`default_nettype wire

/* inv_shift_serializer.sv */
`timescale 1ns/10ps
`default_nettype none

module inv_shift_serializer (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    load_shift,
    input  aes_dec_pkg::state_t     state_in,
    output aes_dec_pkg::byte_beat_t beat_out
);
    import aes_dec_pkg::*;

    state_t     shifted;
    state_t     shift_q;
    logic [4:0] beats_left;

    // Inverse ShiftRows, row r rotates right by r columns
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                shifted[4*c + r] = state_in[4*((c - r + 4) % 4) + r];
            end
        end
    end

    // Beat counter
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            beats_left <= '0;
        else if (load_shift)
            beats_left <= 5'd16;
        else if (beats_left != '0)
            beats_left <= beats_left - 1'b1;
    end

    // Byte 0 leaves first, the rest move down one slot per beat
    always_ff @(posedge clk)
    begin
        if (load_shift)
            shift_q <= shifted;
        else if (beats_left != '0)
            shift_q <= {8'h00, shift_q[15:1]};
    end

    assign beat_out.valid = (beats_left != '0);
    assign beat_out.data  = shift_q[0];

    // Controller must wait for the collector before reloading
    a_no_overlap: assert property (@(posedge clk) disable iff (!resetn)
        load_shift |-> (beats_left == '0))
        else $error("load_shift while bytes are still being sent");

endmodule

`default_nettype wire

/* round_key_mixer.sv */
`timescale 1ns/10ps
`default_nettype none

module round_key_mixer (
    input  logic                clk,
    input  logic                resetn,
    input  logic                add_key_first,
    input  logic                add_key,
    input  logic                inv_mix,
    input  aes_dec_pkg::block_t cipher_text,
    input  aes_dec_pkg::block_t round_key,
    input  aes_dec_pkg::state_t collected,
    output aes_dec_pkg::state_t state_out
);
    import aes_dec_pkg::*;

    state_t work_q;
    state_t mixed;

    // Multiply by 2 in GF(2^8) with reduction by the AES polynomial
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // Multiply by a 4-bit constant using one doubling per bit
    function automatic logic [7:0] gf_mul(input logic [7:0] b, input logic [3:0] k);
        logic [7:0] x2;
        logic [7:0] x4;
        logic [7:0] x8;
        x2 = xtime(b);
        x4 = xtime(x2);
        x8 = xtime(x4);
        return (k[0] ? b : 8'h00) ^ (k[1] ? x2 : 8'h00) ^
               (k[2] ? x4 : 8'h00) ^ (k[3] ? x8 : 8'h00);
    endfunction

    // Inverse MixColumns uses circulant rows of 14 11 13 9
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                mixed[4*c + r] = gf_mul(work_q[4*c + r], 4'd14) ^
                                 gf_mul(work_q[4*c + (r + 1) % 4], 4'd11) ^
                                 gf_mul(work_q[4*c + (r + 2) % 4], 4'd13) ^
                                 gf_mul(work_q[4*c + (r + 3) % 4], 4'd9);
            end
        end
    end

    // Working state takes one update per strobe
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            work_q <= '0;
        else if (add_key_first)
            work_q <= state_t'(cipher_text ^ round_key);
        else if (add_key)
            work_q <= collected ^ state_t'(round_key);
        else if (inv_mix)
            work_q <= mixed;
    end

    assign state_out = work_q;

endmodule

`default_nettype wire

/* src.f */
+incdir+.
aes_dec_pkg.sv
aes_dec_ctrl.sv
inv_shift_serializer.sv
inv_sbox_rom.sv
byte_collector.sv
round_key_mixer.sv
aes256_dec.sv
tb_aes256_dec.sv

/* tb_aes_model.svh */
`default_nettype none

// Reference AES model, byte b is row b%4 of column b/4 at bits 8b+7:8b

// GF(2^8) product, shift-and-add with the AES polynomial
function automatic logic [7:0] gf_mult(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++)
    begin
        if (b[i])
            p = p ^ x;
        x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    end
    return p;
endfunction

// Forward S-box found by searching the inverse table
function automatic logic [7:0] sbox_fwd(input logic [7:0] x);
    logic [7:0] y;
    y = 8'h00;
    for (int i = 0; i < 256; i++)
        if (aes_dec_pkg::INV_SBOX[i] == x)
            y = i[7:0];
    return y;
endfunction

function automatic logic [31:0] sub_word(input logic [31:0] w);
    logic [31:0] r;
    for (int j = 0; j < 4; j++)
        r[8*j +: 8] = sbox_fwd(w[8*j +: 8]);
    return r;
endfunction

// Standard hex order (first byte leftmost) into the block layout
function automatic aes_dec_pkg::block_t be_to_block(input logic [127:0] be);
    aes_dec_pkg::block_t blk;
    for (int b = 0; b < 16; b++)
        blk[8*b +: 8] = be[127 - 8*b -: 8];
    return blk;
endfunction

// AES-256 key schedule, fifteen round keys
function automatic logic [14:0][127:0] expand_key(input logic [255:0] key_be);
    logic [59:0][31:0]  w;
    logic [31:0]        t;
    logic [7:0]         rcon;
    logic [14:0][127:0] keys;
    rcon = 8'h01;
    for (int i = 0; i < 8; i++)
        for (int j = 0; j < 4; j++)
            w[i][8*j +: 8] = key_be[255 - 8*(4*i + j) -: 8];
    for (int i = 8; i < 60; i++)
    begin
        t = w[i-1];
        if (i % 8 == 0)
        begin
            // RotWord then SubWord and the round constant
            t = sub_word({t[7:0], t[31:8]}) ^ {24'h0, rcon};
            rcon = gf_mult(rcon, 8'h02);
        end
        else if (i % 8 == 4)
            t = sub_word(t);
        w[i] = w[i-8] ^ t;
    end
    for (int k = 0; k < 15; k++)
        keys[k] = {w[4*k+3], w[4*k+2], w[4*k+1], w[4*k]};
    return keys;
endfunction

// Textbook inverse cipher on a byte array
function automatic aes_dec_pkg::block_t inv_cipher_ref(input aes_dec_pkg::block_t ct,
                                                       input logic [14:0][127:0] keys,
                                                       input int rounds);
    logic [7:0] s [16];
    logic [7:0] t [16];
    aes_dec_pkg::block_t res;
    for (int b = 0; b < 16; b++)
        s[b] = ct[8*b +: 8] ^ keys[rounds][8*b +: 8];
    for (int rnd = rounds - 1; rnd >= 0; rnd--)
    begin
        // Row r moves right by r columns, substituted on the way
        for (int c = 0; c < 4; c++)
            for (int r = 0; r < 4; r++)
                t[4*((c + r) % 4) + r] = aes_dec_pkg::INV_SBOX[s[4*c + r]];
        for (int b = 0; b < 16; b++)
            t[b] = t[b] ^ keys[rnd][8*b +: 8];
        for (int c = 0; c < 4; c++)
            for (int r = 0; r < 4; r++)
                if (rnd > 0)
                    s[4*c + r] = gf_mult(t[4*c + r], 8'h0e) ^
                                 gf_mult(t[4*c + (r + 1) % 4], 8'h0b) ^
                                 gf_mult(t[4*c + (r + 2) % 4], 8'h0d) ^
                                 gf_mult(t[4*c + (r + 3) % 4], 8'h09);
                else
                    s[4*c + r] = t[4*c + r];
    end
    for (int b = 0; b < 16; b++)
        res[8*b +: 8] = s[b];
    return res;
endfunction

`default_nettype wire

/* tb_aes256_dec.sv */
`timescale 1ns/10ps
`include "tb_aes_model.svh"
`default_nettype none

module tb_aes256_dec;
    import aes_dec_pkg::*;

    localparam int ROUNDS      = MAX_ROUNDS;
    localparam int CYCLE_LIMIT = 400;
    // Decryption runs in the whole sequence, plus slack
    localparam int RUN_COUNT   = 16;

    logic               clk;
    logic               resetn;
    logic               start;
    block_t             cipher_text;
    block_t             round_key;
    key_addr_t          key_addr;
    logic               done;
    block_t             plain_text;
    logic [14:0][127:0] sched;

    int seed       = 32'hbb83;
    int errors     = 0;
    int checks     = 0;
    int tests_run  = 0;
    int done_count = 0;

    aes256_dec u_aes256_dec (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .cipher_text(cipher_text),
        .round_key  (round_key),
        .key_addr   (key_addr),
        .done       (done),
        .plain_text (plain_text)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Key store answers in the same cycle
    always_comb
        round_key = sched[key_addr];

    always @(posedge clk)
        if (resetn && done)
            done_count <= done_count + 1;

    initial
    begin
        #(RUN_COUNT * CYCLE_LIMIT * 100 + 2000);
        $display("Timeout: watchdog expired before the tests finished");
        $display("Checks failed");
        $finish;
    end

    task automatic compare_block(input block_t got, input block_t expected, input string what);
        checks++;
        if (got !== expected)
        begin
            $display("Fail %0t: %s got %h expected %h", $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic compare_addr(input key_addr_t got, input key_addr_t expected,
                                input string what);
        checks++;
        if (got !== expected)
        begin
            $display("Fail %0t: %s got %0d expected %0d", $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic compare_count(input int got, input int expected, input string what);
        checks++;
        if (got != expected)
        begin
            $display("Fail %0t: %s got %0d expected %0d", $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int err0);
        tests_run++;
        if (errors == err0)
            $display("Test %s: ok", name);
        else
            $display("Test %s: %0d errors", name, errors - err0);
    endtask

    task automatic random_bits(output logic [255:0] v);
        for (int i = 0; i < 8; i++)
            v[32*i +: 32] = $random(seed);
    endtask

    task automatic load_key(input logic [255:0] key_be);
        @(posedge clk);
        sched <= expand_key(key_be);
    endtask

    // Start is sampled on the second edge, ciphertext is used one edge later
    task automatic start_block(input block_t ct);
        @(posedge clk);
        start       <= 1'b1;
        cipher_text <= ct;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_done(input int limit, output bit seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < limit)
        begin
            @(posedge clk);
            seen = done;
            n++;
        end
        if (!seen)
        begin
            $display("Timeout: no done pulse within %0d cycles at %0t", limit, $time);
            errors++;
        end
    endtask

    task automatic run_block(input block_t ct, input block_t expected, input string what);
        bit seen;
        start_block(ct);
        wait_done(CYCLE_LIMIT, seen);
        if (seen)
        begin
            // Output register loads on the edge that ends done
            @(posedge clk);
            compare_block(plain_text, expected, what);
            compare_addr(key_addr, key_addr_t'(ROUNDS), {what, " key_addr"});
        end
    endtask

    task automatic test_reset_state();
        int err0;
        err0 = errors;
        compare_addr(key_addr, key_addr_t'(ROUNDS), "key_addr after reset");
        compare_count(int'(done), 0, "done after reset");
        compare_block(plain_text, '0, "plain_text after reset");
        end_test("reset state", err0);
    endtask

    task automatic test_standard_vector();
        int err0;
        err0 = errors;
        load_key(256'h000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f);
        run_block(be_to_block(128'h8ea2b7ca516745bfeafc49904b496089),
                  be_to_block(128'h00112233445566778899aabbccddeeff), "standard vector");
        end_test("standard vector", err0);
    endtask

    task automatic test_random_blocks();
        logic [255:0] key;
        logic [255:0] data;
        int err0;
        err0 = errors;
        for (int i = 0; i < 10; i++)
        begin
            random_bits(key);
            random_bits(data);
            load_key(key);
            run_block(data[127:0], inv_cipher_ref(data[127:0], expand_key(key), ROUNDS),
                      $sformatf("random block %0d", i));
        end
        end_test("random blocks", err0);
    endtask

    task automatic test_start_while_busy();
        logic [255:0] key;
        logic [255:0] first;
        logic [255:0] second;
        int err0;
        int dones_before;
        bit seen;
        err0 = errors;
        random_bits(key);
        random_bits(first);
        random_bits(second);
        load_key(key);
        dones_before = done_count;
        start_block(first[127:0]);
        repeat (5) @(posedge clk);
        start       <= 1'b1;
        cipher_text <= second[127:0];
        @(posedge clk);
        start <= 1'b0;
        wait_done(CYCLE_LIMIT, seen);
        @(posedge clk);
        compare_block(plain_text, inv_cipher_ref(first[127:0], expand_key(key), ROUNDS),
                      "busy result");
        // A taken second start would finish within one more run
        repeat (CYCLE_LIMIT) @(posedge clk);
        compare_count(done_count - dones_before, 1, "done pulses with busy start");
        end_test("start while busy", err0);
    endtask

    task automatic test_held_output();
        logic [255:0] key;
        logic [255:0] a;
        logic [255:0] b;
        block_t exp_b;
        int err0;
        int dones_before;
        err0 = errors;
        random_bits(key);
        random_bits(a);
        random_bits(b);
        load_key(key);
        exp_b = inv_cipher_ref(b[127:0], expand_key(key), ROUNDS);
        dones_before = done_count;
        run_block(a[127:0], inv_cipher_ref(a[127:0], expand_key(key), ROUNDS), "first of pair");
        run_block(b[127:0], exp_b, "second of pair");
        compare_count(done_count - dones_before, 2, "done pulses for two runs");
        for (int i = 0; i < 20; i++)
        begin
            @(posedge clk);
            compare_block(plain_text, exp_b, $sformatf("held output cycle %0d", i));
        end
        end_test("held output", err0);
    endtask

    initial
    begin
        resetn      = 1'b0;
        start       = 1'b0;
        cipher_text = '0;
        sched       = '0;
        repeat (8) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);
        test_reset_state();
        test_standard_vector();
        test_random_blocks();
        test_start_while_busy();
        test_held_output();
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire
